/* src/spm_macros.svh */
// ----------------------------------------
// Scratchpad memory configuration
// Bus widths, memory depth and the depth
// of the read-return delay line
// ----------------------------------------

`ifndef SPM_MACROS_SVH
`define SPM_MACROS_SVH

// Width of the APB data bus and of a memory word
`define SPM_DATA_W 32

// Width of the APB byte address
`define SPM_ADDR_W 10

// Memory depth in words
`define SPM_WORDS 256

// Register stages between the RAM and the ports on the read path
`define SPM_RD_STAGES 2

`endif

/* src/spm_pkg.sv */
// ----------------------------------------
// Scratchpad memory types
// Data words, word addresses, port tags
// and the arbiter priority state
// ----------------------------------------

`include "spm_macros.svh"

package spm_pkg;

  // One memory or bus data word
  typedef logic [`SPM_DATA_W-1:0] spm_data_t;

  // Word address into the RAM, sized from the memory depth
  typedef logic [$clog2(`SPM_WORDS)-1:0] spm_waddr_t;

  // Index of the requesting port, carried alongside read data
  typedef logic [0:0] spm_tag_t;

  // Port that gets priority when both request in the same cycle
  typedef enum logic {
    PRIO_P0,
    PRIO_P1
  } spm_arb_state_t;

endpackage

/* src/spm_delay_valid_next.sv */
// ----------------------------------------
// Valid-next delay line
// Delays a valid-next flag and its data by
// NumStages cycles, data stages load only
// when their valid-next bit is set
// ----------------------------------------

`timescale 1ns/1ns

module spm_delay_valid_next #(
  parameter int BitWidth  = 1,
  parameter int NumStages = 0
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                in_valid_next,
  input  logic [BitWidth-1:0] in,
  output logic                out_valid_next,
  output logic [BitWidth-1:0] out
);

  if (NumStages == 0) begin : gen_passthru
    // No stages, so the line is just a wire
    assign out_valid_next = in_valid_next;
    assign out            = in;
  end else begin : gen_stages
    // vn_q[i] says data_q[i-1] (or the input for i == 0) is valid this cycle
    logic [NumStages-1:0]               vn_q;
    logic [NumStages-1:0][BitWidth-1:0] data_q;

    // ------------------------------------
    // Valid-next shift register
    // ------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        vn_q <= '0;
      end else begin
        vn_q[0] <= in_valid_next;
        for (int i = 1; i < NumStages; i++) begin
          vn_q[i] <= vn_q[i-1];
        end
      end
    end

    // ------------------------------------
    // Data stages
    // ------------------------------------
    // Each wide stage is clock-enabled by its own valid-next bit,
    // so it only toggles when the stage ahead of it holds real data
    always_ff @(posedge clk) begin
      if (vn_q[0]) begin
        data_q[0] <= in;
      end
      for (int i = 1; i < NumStages; i++) begin
        if (vn_q[i]) begin
          data_q[i] <= data_q[i-1];
        end
      end
    end

    assign out_valid_next = vn_q[NumStages-1];
    assign out            = data_q[NumStages-1];
  end

endmodule

/* src/spm_apb_port.sv */
// ----------------------------------------
// APB completer port
// Checks alignment, requests the shared
// memory and completes the APB transfer
// ----------------------------------------

`timescale 1ns/1ns

`include "spm_macros.svh"

module spm_apb_port (
  input  logic                   clk,
  input  logic                   arst_n,
  // APB completer side
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`SPM_ADDR_W-1:0] paddr,
  input  spm_pkg::spm_data_t     pwdata,
  output spm_pkg::spm_data_t     prdata,
  output logic                   pready,
  output logic                   pslverr,
  // Request towards the arbiter
  output logic                   req,
  output logic                   we,
  output spm_pkg::spm_waddr_t    waddr,
  output spm_pkg::spm_data_t     wdata,
  input  logic                   gnt,
  input  logic                   rsp_valid,
  input  spm_pkg::spm_data_t     rsp_data
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RSP,
    DONE
  } port_state_t;

  port_state_t state_q;
  port_state_t state_d;
  logic        access;
  logic        aligned;
  logic        rd_done;

  // ----------------------------------------
  // Transfer decode
  // ----------------------------------------
  // Access phase of an APB transfer addressed to this port
  assign access  = psel & penable;
  // Only word-aligned addresses reach the memory
  assign aligned = (paddr[1:0] == 2'b00);
  // A read finishes in the cycle its data comes back
  assign rd_done = (state_q == WAIT_RSP) && rsp_valid;

  // The requester holds its signals until pready, so they feed the arbiter directly
  assign we    = pwrite;
  assign waddr = paddr[`SPM_ADDR_W-1:2];
  assign wdata = pwdata;

  // Request in the first access cycle, and keep requesting until granted
  assign req = ((state_q == IDLE) && access && aligned) || (state_q == WAIT_GNT);

  // ----------------------------------------
  // Transfer FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (access && aligned) begin
          if (gnt) begin
            state_d = pwrite ? DONE : WAIT_RSP;
          end else begin
            state_d = WAIT_GNT;
          end
        end
      end
      WAIT_GNT: begin
        // Once granted, the request is never raised again for this transfer
        if (gnt) begin
          state_d = pwrite ? DONE : WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if (rsp_valid) begin
          state_d = IDLE;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // APB response
  // ----------------------------------------
  // Unaligned accesses complete at once with an error and never touch memory
  assign pslverr = (state_q == IDLE) && access && !aligned;
  assign pready  = pslverr || (state_q == DONE) || rd_done;
  // Return data is shared by both ports, so pass it only when it is ours
  assign prdata  = rd_done ? rsp_data : '0;

endmodule

/* src/spm_arbiter.sv */
// ----------------------------------------
// Round-robin memory arbiter
// Grants one port per cycle onto the RAM
// and steers read data back by its tag
// ----------------------------------------

`timescale 1ns/1ns

module spm_arbiter (
  input  logic                       clk,
  input  logic                       arst_n,
  // Port 0 request
  input  logic                       req0,
  input  logic                       we0,
  input  spm_pkg::spm_waddr_t        waddr0,
  input  spm_pkg::spm_data_t         wdata0,
  // Port 1 request
  input  logic                       req1,
  input  logic                       we1,
  input  spm_pkg::spm_waddr_t        waddr1,
  input  spm_pkg::spm_data_t         wdata1,
  output logic                       gnt0,
  output logic                       gnt1,
  // RAM access
  output logic                       mem_en,
  output logic                       mem_we,
  output spm_pkg::spm_waddr_t        mem_addr,
  output spm_pkg::spm_data_t         mem_wdata,
  output spm_pkg::spm_tag_t          mem_tag,
  // Read return from the delay line
  input  logic                       ret_valid_next,
  input  spm_pkg::spm_data_t         ret_data,
  input  spm_pkg::spm_tag_t          ret_tag,
  output logic                       rsp_valid0,
  output logic                       rsp_valid1,
  output spm_pkg::spm_data_t         rsp_data
);

  spm_pkg::spm_arb_state_t state_q;
  logic                    ret_valid_q;

  // ----------------------------------------
  // Grant
  // ----------------------------------------
  // Port 0 wins when alone or when it holds priority
  assign gnt0 = req0 && (!req1 || (state_q == spm_pkg::PRIO_P0));
  assign gnt1 = req1 && !gnt0;

  // Priority moves to the other port after every grant
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= spm_pkg::PRIO_P0;
    end else if (gnt0) begin
      state_q <= spm_pkg::PRIO_P1;
    end else if (gnt1) begin
      state_q <= spm_pkg::PRIO_P0;
    end
  end

  // RAM side is a plain mux on the winning port
  assign mem_en    = gnt0 | gnt1;
  assign mem_we    = gnt1 ? we1 : we0;
  assign mem_addr  = gnt1 ? waddr1 : waddr0;
  assign mem_wdata = gnt1 ? wdata1 : wdata0;
  assign mem_tag   = gnt1;

  // ----------------------------------------
  // Read return
  // ----------------------------------------
  // Valid-next runs a cycle ahead, so one flop marks when ret_data is valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ret_valid_q <= 1'b0;
    end else begin
      ret_valid_q <= ret_valid_next;
    end
  end

  assign rsp_valid0 = ret_valid_q && (ret_tag == 1'b0);
  assign rsp_valid1 = ret_valid_q && (ret_tag == 1'b1);
  assign rsp_data   = ret_data;

endmodule

/* src/spm_ram.sv */
// ----------------------------------------
// Scratchpad RAM
// Single-port synchronous memory, read data
// is registered with the requester's tag
// ----------------------------------------

`timescale 1ns/1ns

`include "spm_macros.svh"

module spm_ram (
  input  logic                clk,
  input  logic                en,
  input  logic                we,
  input  spm_pkg::spm_waddr_t addr,
  input  spm_pkg::spm_data_t  wdata,
  input  spm_pkg::spm_tag_t   tag,
  output spm_pkg::spm_data_t  rd_data,
  output spm_pkg::spm_tag_t   rd_tag
);

  // Storage array, contents are undefined until written
  spm_pkg::spm_data_t mem [`SPM_WORDS];

  // ----------------------------------------
  // Access
  // ----------------------------------------
  // One access per cycle: a write updates the array, a read loads
  // the output register, which holds its value between reads
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rd_data <= mem[addr];
        // The tag travels with the data so the return path can route it
        rd_tag  <= tag;
      end
    end
  end

endmodule

/* src/spm_top.sv */
// ----------------------------------------
// Dual-port APB scratchpad
// Two peer APB completers share one RAM
// through a round-robin arbiter, read data
// returns over a valid-next delay line
// ----------------------------------------

`timescale 1ns/1ns

`include "spm_macros.svh"

module spm_top (
  input  logic                   clk,
  input  logic                   arst_n,
  // APB port 0
  input  logic                   p0_psel,
  input  logic                   p0_penable,
  input  logic                   p0_pwrite,
  input  logic [`SPM_ADDR_W-1:0] p0_paddr,
  input  spm_pkg::spm_data_t     p0_pwdata,
  output spm_pkg::spm_data_t     p0_prdata,
  output logic                   p0_pready,
  output logic                   p0_pslverr,
  // APB port 1
  input  logic                   p1_psel,
  input  logic                   p1_penable,
  input  logic                   p1_pwrite,
  input  logic [`SPM_ADDR_W-1:0] p1_paddr,
  input  spm_pkg::spm_data_t     p1_pwdata,
  output spm_pkg::spm_data_t     p1_prdata,
  output logic                   p1_pready,
  output logic                   p1_pslverr
);

  // Port to arbiter
  logic                req0;
  logic                we0;
  spm_pkg::spm_waddr_t waddr0;
  spm_pkg::spm_data_t  wdata0;
  logic                gnt0;
  logic                rsp_valid0;
  logic                req1;
  logic                we1;
  spm_pkg::spm_waddr_t waddr1;
  spm_pkg::spm_data_t  wdata1;
  logic                gnt1;
  logic                rsp_valid1;
  spm_pkg::spm_data_t  rsp_data;

  // Arbiter to RAM
  logic                mem_en;
  logic                mem_we;
  spm_pkg::spm_waddr_t mem_addr;
  spm_pkg::spm_data_t  mem_wdata;
  spm_pkg::spm_tag_t   mem_tag;
  spm_pkg::spm_data_t  rd_data;
  spm_pkg::spm_tag_t   rd_tag;

  // Return path, tag sits above the data word
  logic                  rd_valid_next;
  logic [`SPM_DATA_W:0]  ret_bus;
  logic                  ret_valid_next;

  // ----------------------------------------
  // APB ports
  // ----------------------------------------
  spm_apb_port u_port0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (p0_psel),
    .penable   (p0_penable),
    .pwrite    (p0_pwrite),
    .paddr     (p0_paddr),
    .pwdata    (p0_pwdata),
    .prdata    (p0_prdata),
    .pready    (p0_pready),
    .pslverr   (p0_pslverr),
    .req       (req0),
    .we        (we0),
    .waddr     (waddr0),
    .wdata     (wdata0),
    .gnt       (gnt0),
    .rsp_valid (rsp_valid0),
    .rsp_data  (rsp_data)
  );

  spm_apb_port u_port1 (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (p1_psel),
    .penable   (p1_penable),
    .pwrite    (p1_pwrite),
    .paddr     (p1_paddr),
    .pwdata    (p1_pwdata),
    .prdata    (p1_prdata),
    .pready    (p1_pready),
    .pslverr   (p1_pslverr),
    .req       (req1),
    .we        (we1),
    .waddr     (waddr1),
    .wdata     (wdata1),
    .gnt       (gnt1),
    .rsp_valid (rsp_valid1),
    .rsp_data  (rsp_data)
  );

  // ----------------------------------------
  // Arbiter and memory
  // ----------------------------------------
  spm_arbiter u_arbiter (
    .clk            (clk),
    .arst_n         (arst_n),
    .req0           (req0),
    .we0            (we0),
    .waddr0         (waddr0),
    .wdata0         (wdata0),
    .req1           (req1),
    .we1            (we1),
    .waddr1         (waddr1),
    .wdata1         (wdata1),
    .gnt0           (gnt0),
    .gnt1           (gnt1),
    .mem_en         (mem_en),
    .mem_we         (mem_we),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .mem_tag        (mem_tag),
    .ret_valid_next (ret_valid_next),
    .ret_data       (ret_bus[`SPM_DATA_W-1:0]),
    .ret_tag        (ret_bus[`SPM_DATA_W]),
    .rsp_valid0     (rsp_valid0),
    .rsp_valid1     (rsp_valid1),
    .rsp_data       (rsp_data)
  );

  spm_ram u_ram (
    .clk     (clk),
    .en      (mem_en),
    .we      (mem_we),
    .addr    (mem_addr),
    .wdata   (mem_wdata),
    .tag     (mem_tag),
    .rd_data (rd_data),
    .rd_tag  (rd_tag)
  );

  // A read enable is the valid-next for the RAM output register
  assign rd_valid_next = mem_en & ~mem_we;

  // ----------------------------------------
  // Read-return wire model
  // ----------------------------------------
  spm_delay_valid_next #(
    .BitWidth  (`SPM_DATA_W + 1),
    .NumStages (`SPM_RD_STAGES)
  ) u_delay (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_valid_next  (rd_valid_next),
    .in             ({rd_tag, rd_data}),
    .out_valid_next (ret_valid_next),
    .out            (ret_bus)
  );

endmodule

/* testbench/spm_sva.sv */
// ----------------------------------------
// Scratchpad protocol assertions
// Bound into the top level, checks APB
// completion, read return timing and the
// delay line's valid-next path
// ----------------------------------------

`timescale 1ns/1ns

`include "spm_macros.svh"

module spm_sva (
  input logic clk,
  input logic arst_n,
  input logic p0_psel,
  input logic p0_penable,
  input logic p0_pready,
  input logic p1_psel,
  input logic p1_penable,
  input logic p1_pready,
  input logic gnt0,
  input logic we0,
  input logic rsp_valid0,
  input logic gnt1,
  input logic we1,
  input logic rsp_valid1,
  input logic rd_valid_next,
  input logic ret_valid_next
);

  // Cycles from a read grant to its response at the port
  localparam int rd_lat = `SPM_RD_STAGES + 1;

  // ----------------------------------------
  // APB completion
  // ----------------------------------------
  a_p0_pready: assert property (@(posedge clk) disable iff (!arst_n)
    p0_pready |-> (p0_psel && p0_penable)) else $error("port 0 pready outside access phase");
  a_p1_pready: assert property (@(posedge clk) disable iff (!arst_n)
    p1_pready |-> (p1_psel && p1_penable)) else $error("port 1 pready outside access phase");

  // ----------------------------------------
  // Read return timing
  // ----------------------------------------
  // Every read grant comes back to its own port a fixed time later
  a_p0_rsp: assert property (@(posedge clk) disable iff (!arst_n)
    (gnt0 && !we0) |-> ##rd_lat rsp_valid0) else $error("port 0 read response missing");
  a_p1_rsp: assert property (@(posedge clk) disable iff (!arst_n)
    (gnt1 && !we1) |-> ##rd_lat rsp_valid1) else $error("port 1 read response missing");

  // And no response shows up without a matching grant
  a_p0_src: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid0 |-> $past(gnt0 && !we0, rd_lat)) else $error("port 0 response without grant");
  a_p1_src: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid1 |-> $past(gnt1 && !we1, rd_lat)) else $error("port 1 response without grant");

  // The delay line is a pure shift of valid-next
  a_delay: assert property (@(posedge clk) disable iff (!arst_n)
    ret_valid_next == $past(rd_valid_next, `SPM_RD_STAGES)) else $error("delay line mismatch");

endmodule

bind spm_top spm_sva u_sva (
  .clk            (clk),
  .arst_n         (arst_n),
  .p0_psel        (p0_psel),
  .p0_penable     (p0_penable),
  .p0_pready      (p0_pready),
  .p1_psel        (p1_psel),
  .p1_penable     (p1_penable),
  .p1_pready      (p1_pready),
  .gnt0           (gnt0),
  .we0            (we0),
  .rsp_valid0     (rsp_valid0),
  .gnt1           (gnt1),
  .we1            (we1),
  .rsp_valid1     (rsp_valid1),
  .rd_valid_next  (rd_valid_next),
  .ret_valid_next (ret_valid_next)
);

/* testbench/spm_tb.sv */
// ----------------------------------------
// Scratchpad testbench
// Drives both APB ports with directed and
// random transfers and checks them against
// a memory model kept in the testbench
// ----------------------------------------

`timescale 1ns/1ns

`include "spm_macros.svh"

module spm_tb;

  localparam int clk_period = 20;
  localparam int rd_lat     = `SPM_RD_STAGES + 1;
  // Longest access phase that round-robin allows under contention
  localparam int max_access = 2 * (`SPM_RD_STAGES + 2);
  localparam int num_random = 200;
  // The fill, three directed tests with four transfers each and both random streams
  localparam int num_xfers  = `SPM_WORDS + 12 + 2 * num_random;
  localparam int timeout_ns = (num_xfers + 16) * 20 * clk_period;

  logic                                clk;
  logic                                arst_n;
  logic [1:0]                          psel;
  logic [1:0]                          penable;
  logic [1:0]                          pwrite;
  logic [1:0][`SPM_ADDR_W-1:0]         paddr;
  logic [1:0][`SPM_DATA_W-1:0]         pwdata;
  logic [1:0][`SPM_DATA_W-1:0]         prdata;
  logic [1:0]                          pready;
  logic [1:0]                          pslverr;

  spm_pkg::spm_data_t model [`SPM_WORDS];
  logic [31:0]        rng_state;
  int                 checks;
  int                 errors;
  int                 errors_at_start;

  spm_top dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .p0_psel    (psel[0]),
    .p0_penable (penable[0]),
    .p0_pwrite  (pwrite[0]),
    .p0_paddr   (paddr[0]),
    .p0_pwdata  (pwdata[0]),
    .p0_prdata  (prdata[0]),
    .p0_pready  (pready[0]),
    .p0_pslverr (pslverr[0]),
    .p1_psel    (psel[1]),
    .p1_penable (penable[1]),
    .p1_pwrite  (pwrite[1]),
    .p1_paddr   (paddr[1]),
    .p1_pwdata  (pwdata[1]),
    .p1_prdata  (prdata[1]),
    .p1_pready  (pready[1]),
    .p1_pslverr (pslverr[1])
  );

  always #(clk_period / 2) clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Numerical Recipes LCG whose upper bits are the useful ones
  function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Fill pattern built from every bit of the word address
  function automatic spm_pkg::spm_data_t fill_word(input logic [7:0] w);
    return {w, ~w, w ^ 8'h5a, w + 8'h3c};
  endfunction

  task automatic expect_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("Fail at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic expect_value(input string what, input spm_pkg::spm_data_t got,
                              input spm_pkg::spm_data_t exp);
    checks++;
    assert (got == exp) else begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expect_int(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // One APB transfer where lat counts cycles after the first access cycle
  task automatic apb_xfer(input bit port, input logic wr, input logic [`SPM_ADDR_W-1:0] addr,
                          input spm_pkg::spm_data_t wd, output spm_pkg::spm_data_t rd,
                          output logic err, output int lat);
    @(negedge clk);
    psel[port]    = 1'b1;
    penable[port] = 1'b0;
    pwrite[port]  = wr;
    paddr[port]   = addr;
    pwdata[port]  = wd;
    @(negedge clk);
    penable[port] = 1'b1;
    lat = 0;
    // Outputs are sampled mid low phase away from both clock edges
    #(clk_period / 4);
    while (!pready[port]) begin
      @(negedge clk);
      lat++;
      #(clk_period / 4);
    end
    rd  = prdata[port];
    err = pslverr[port];
    @(negedge clk);
    psel[port]    = 1'b0;
    penable[port] = 1'b0;
  endtask

  // Random stream on one port confined to that port's half of memory
  task automatic random_port(input bit port, input int count);
    logic [31:0]        r;
    logic [7:0]         w;
    logic               wr;
    logic               err;
    int                 lat;
    spm_pkg::spm_data_t wd;
    spm_pkg::spm_data_t rd;
    spm_pkg::spm_data_t exp;
    for (int i = 0; i < count; i++) begin
      r   = rand32();
      wr  = r[31];
      w   = {port, r[30:24]};
      wd  = rand32();
      exp = model[w];
      apb_xfer(port, wr, {w, 2'b00}, wd, rd, err, lat);
      expect_true(!err, "random transfer answered with an error");
      expect_true(lat + 1 <= max_access, "access phase too long under contention");
      if (wr) begin
        model[w] = wd;
      end else begin
        expect_value("random read data", rd, exp);
      end
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [7:0]         w;
    logic               err;
    int                 lat;
    spm_pkg::spm_data_t wd;
    spm_pkg::spm_data_t rd;
    clk             = 1'b0;
    arst_n          = 1'b0;
    psel            = '0;
    penable         = '0;
    pwrite          = '0;
    paddr           = '0;
    pwdata          = '0;
    rng_state       = 32'he557;
    checks          = 0;
    errors          = 0;
    errors_at_start = 0;

    // Outputs stay quiet through reset and the cycle after it
    repeat (16) begin
      @(negedge clk);
      expect_true(pready == 2'b00 && pslverr == 2'b00, "pready or pslverr high in reset");
    end
    arst_n = 1'b1;
    // First clock edge out of reset has passed when this is sampled
    @(negedge clk);
    #(clk_period / 4);
    expect_true(pready == 2'b00 && pslverr == 2'b00, "pready or pslverr high after reset");
    end_test("reset");

    // Known contents everywhere written through alternating ports
    for (int a = 0; a < `SPM_WORDS; a++) begin
      w = a[7:0];
      apb_xfer(w[0], 1'b1, {w, 2'b00}, fill_word(w), rd, err, lat);
      model[w] = fill_word(w);
    end
    end_test("fill");

    for (int p = 0; p < 2; p++) begin
      w  = {7'h10, p[0]};
      wd = rand32();
      apb_xfer(p[0], 1'b1, {w, 2'b00}, wd, rd, err, lat);
      expect_true(!err, "aligned write answered with an error");
      expect_int("write latency", lat, 1);
      model[w] = wd;
      apb_xfer(p[0], 1'b0, {w, 2'b00}, '0, rd, err, lat);
      expect_int("read latency", lat, rd_lat);
      expect_value("read data", rd, model[w]);
    end
    end_test("uncontended");

    // Write on one port and read back on the other
    for (int p = 0; p < 2; p++) begin
      w  = {7'h30, p[0]};
      wd = rand32();
      apb_xfer(p[0], 1'b1, {w, 2'b00}, wd, rd, err, lat);
      model[w] = wd;
      apb_xfer(!p[0], 1'b0, {w, 2'b00}, '0, rd, err, lat);
      expect_value("cross-port read data", rd, model[w]);
    end
    end_test("cross_port");

    fork
      random_port(1'b0, num_random);
      random_port(1'b1, num_random);
    join
    end_test("random_contention");

    // Unaligned writes must not reach memory
    for (int p = 0; p < 2; p++) begin
      w = {7'h50, p[0]};
      apb_xfer(p[0], 1'b1, {w, p[0], !p[0]}, ~model[w], rd, err, lat);
      expect_true(err, "unaligned access not answered with pslverr");
      expect_int("unaligned latency", lat, 0);
      apb_xfer(p[0], 1'b0, {w, 2'b00}, '0, rd, err, lat);
      expect_value("word after unaligned write", rd, model[w]);
    end
    end_test("unaligned");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the number of transfers
  initial begin
    #(timeout_ns);
    $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* build.f */
+incdir+src
src/spm_pkg.sv
src/spm_delay_valid_next.sv
src/spm_apb_port.sv
src/spm_arbiter.sv
src/spm_ram.sv
src/spm_top.sv
testbench/spm_sva.sv
testbench/spm_tb.sv

/* Makefile */
# Verilator build and run for the dual-port APB scratchpad
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= spm_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ns -j 0
PASS_MSG  ?= RESULT: PASS

# Sources come from the file list, headers are added so edits trigger a rebuild
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Shows the full output and fails unless the pass line is present
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

# Quiet variant that only reports the outcome
check: $(BIN)
	@./$(BIN) | grep -qx "$(PASS_MSG)" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
